// File: tb.f
+incdir+common
common/rv_pkg.sv
alu/alu.sv
hdl/instr_decode.sv
hdl/reg_file.sv
hdl/exec_core.sv
test/tb_exec_core.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_exec_core
FILELIST  = tb.f
OBJ_DIR   = obj_dir
PASS_MSG  = ALL CHECKS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: test/tb_exec_core.sv
`include "rv_consts.svh"

module tb_exec_core;

    logic                clk = 1'b0;
    logic                arst_n;
    logic                instr_valid;
    rv_pkg::instr_t      instr;
    logic                illegal;
    logic                result_valid;
    rv_pkg::reg_addr_t   result_rd;
    rv_pkg::word_t       result;
    rv_pkg::alu_flags_t  result_flags;

    // architectural register state and pending expectations
    logic [31:0] ref_regs [0:31];
    int          exp_cyc [$];
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_res [$];
    logic [3:0]  exp_flags [$];
    int          ill_cyc [$];

    int          cyc = 0;
    int          mismatch_count = 0;
    int          strobe_errors = 0;
    int          timeout_errors = 0;

    exec_core uut (
        .clk          (clk),
        .arst_n       (arst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .illegal      (illegal),
        .result_valid (result_valid),
        .result_rd    (result_rd),
        .result       (result),
        .result_flags (result_flags)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %08h expected %08h", $time, what, got, exp);
            mismatch_count++;
        end
    endtask

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, `OPC_OP_IMM};
    endfunction

    // RV32I result and flags of one instruction word from the model registers
    function automatic logic [31:0] ref_exec(input logic [31:0] ins,
                                             output logic [3:0] flg, output logic legal);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic        is_imm;
        logic        is_sub;
        logic [31:0] a;
        logic [31:0] b;
        logic [32:0] wide;
        logic [31:0] r;
        logic [4:0]  sh;
        opc    = ins[6:0];
        f3     = ins[14:12];
        f7     = ins[31:25];
        is_imm = (opc == `OPC_OP_IMM);
        legal  = 1'b0;
        if (opc == `OPC_OP) begin
            legal = (f7 == 7'h00) || ((f7 == 7'h20) && (f3 == 3'd0 || f3 == 3'd5));
        end else if (is_imm) begin
            if (f3 == 3'd1) begin
                legal = (f7 == 7'h00);
            end else if (f3 == 3'd5) begin
                legal = (f7 == 7'h00) || (f7 == 7'h20);
            end else begin
                legal = 1'b1;
            end
        end
        // x0 is never written in the model
        a      = ref_regs[ins[19:15]];
        b      = is_imm ? {{20{ins[31]}}, ins[31:20]} : ref_regs[ins[24:20]];
        sh     = b[4:0];
        is_sub = !is_imm && (f7 == 7'h20) && (f3 == 3'd0);
        case (f3)
            3'd0:    r = is_sub ? a - b : a + b;
            3'd1:    r = a << sh;
            3'd2:    r = {31'd0, $signed(a) < $signed(b)};
            3'd3:    r = {31'd0, a < b};
            3'd4:    r = a ^ b;
            3'd5:    r = (f7 == 7'h20) ? 32'($signed(a) >>> sh) : a >> sh;
            3'd6:    r = a | b;
            default: r = a & b;
        endcase
        flg = 4'd0;
        if (f3 == 3'd0 && is_sub) begin
            flg[`FLAG_OV] = (a[31] != b[31]) && (r[31] != a[31]);
            flg[`FLAG_CY] = (a >= b);
        end else if (f3 == 3'd0) begin
            wide          = {1'b0, a} + {1'b0, b};
            flg[`FLAG_OV] = (a[31] == b[31]) && (r[31] != a[31]);
            flg[`FLAG_CY] = wide[32];
        end else if (f3 == 3'd2 || f3 == 3'd3) begin
            // no borrow out of a - b
            flg[`FLAG_CY] = (a >= b);
        end
        flg[`FLAG_Z] = (r == 32'd0);
        flg[`FLAG_N] = r[31];
        return r;
    endfunction

    // legal R or I word drawn from a small register pool so results feed each other
    function automatic logic [31:0] rand_instr();
        logic [31:0] rnd;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        logic [31:0] w;
        rnd = $urandom;
        f3  = rnd[2:0];
        f7  = (rnd[12] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
        case (rnd[15:13])
            3'd0:    imm = 12'h800;
            3'd1:    imm = 12'hfff;
            3'd2:    imm = 12'h7ff;
            default: imm = rnd[27:16];
        endcase
        if (f3 == 3'd1 || f3 == 3'd5) begin
            imm = {f7, rnd[20:16]};
        end
        if (rnd[28]) begin
            w = r_type(f7, {2'b00, rnd[11:9]}, {2'b00, rnd[8:6]}, f3, {2'b00, rnd[5:3]});
        end else begin
            w = i_type(imm, {2'b00, rnd[8:6]}, f3, {2'b00, rnd[5:3]});
        end
        return w;
    endfunction

    function automatic logic [31:0] bad_instr();
        logic [31:0] rnd;
        logic [31:0] w;
        rnd = $urandom;
        case (rnd[1:0])
            2'd0:    w = {rnd[31:7], 7'b0110111};
            2'd1:    w = {7'b0000001, rnd[24:7], `OPC_OP};
            2'd2:    w = {7'h20, rnd[24:15], 3'b100, rnd[11:7], `OPC_OP};
            default: w = {7'h20, rnd[24:15], 3'b001, rnd[11:7], `OPC_OP_IMM};
        endcase
        return w;
    endfunction

    // drive one strobe and queue what the core must answer
    task automatic issue(input logic [31:0] ins);
        logic [31:0] r;
        logic [3:0]  flg;
        logic        legal;
        instr_valid = 1'b1;
        instr       = ins;
        r = ref_exec(ins, flg, legal);
        if (legal) begin
            exp_cyc.push_back(cyc + 2);
            exp_rd.push_back(ins[11:7]);
            exp_res.push_back(r);
            exp_flags.push_back(flg);
            if (ins[11:7] != 5'd0) begin
                ref_regs[ins[11:7]] = r;
            end
        end else begin
            ill_cyc.push_back(cyc + 1);
        end
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
    endtask

    task automatic idle();
        @(posedge clk);
        #1;
    endtask

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        if (!arst_n) begin
            check_value("result_valid in reset", 32'(result_valid), 32'd0);
            check_value("illegal in reset", 32'(illegal), 32'd0);
            check_value("result_rd in reset", 32'(result_rd), 32'd0);
            check_value("result in reset", result, 32'd0);
            check_value("result_flags in reset", 32'(result_flags), 32'd0);
        end else begin
            if (exp_cyc.size() != 0 && exp_cyc[0] == cyc) begin
                if (!result_valid) begin
                    $display("Error at %0t: result_valid missing in cycle %0d", $time, cyc);
                    strobe_errors++;
                end else begin
                    check_value("result_rd", 32'(result_rd), 32'(exp_rd[0]));
                    check_value("result", result, exp_res[0]);
                    check_value("result_flags", 32'(result_flags), 32'(exp_flags[0]));
                end
                void'(exp_cyc.pop_front());
                void'(exp_rd.pop_front());
                void'(exp_res.pop_front());
                void'(exp_flags.pop_front());
            end else if (result_valid) begin
                $display("Error at %0t: result_valid with no result due in cycle %0d",
                         $time, cyc);
                strobe_errors++;
            end
            if (ill_cyc.size() != 0 && ill_cyc[0] == cyc) begin
                if (!illegal) begin
                    $display("Error at %0t: illegal missing in cycle %0d", $time, cyc);
                    strobe_errors++;
                end
                void'(ill_cyc.pop_front());
            end else if (illegal) begin
                $display("Error at %0t: illegal raised for a legal or absent word", $time);
                strobe_errors++;
            end
        end
    end

    initial begin
        int          waited;
        logic [31:0] rnd;
        void'($urandom(32'h7614_3484));
        arst_n      = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = 32'd0;
        end
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;

        // boundary values issued back to back
        issue(r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd3));
        issue(i_type(12'hfff, 5'd0, 3'd0, 5'd1));
        issue(i_type(12'h01f, 5'd1, 3'd1, 5'd2));
        issue(i_type(12'd33, 5'd0, 3'd0, 5'd5));
        // shift by 33 acts as shift by 1
        issue(r_type(7'h00, 5'd5, 5'd1, 3'd1, 5'd6));
        issue(r_type(7'h00, 5'd5, 5'd2, 3'd5, 5'd7));
        issue(r_type(7'h20, 5'd5, 5'd2, 3'd5, 5'd7));
        issue(r_type(7'h00, 5'd1, 5'd2, 3'd2, 5'd8));
        issue(r_type(7'h00, 5'd1, 5'd2, 3'd3, 5'd8));
        issue(r_type(7'h00, 5'd2, 5'd1, 3'd2, 5'd8));
        issue(r_type(7'h00, 5'd2, 5'd1, 3'd3, 5'd9));
        issue(r_type(7'h00, 5'd2, 5'd2, 3'd0, 5'd9));
        issue(r_type(7'h20, 5'd1, 5'd2, 3'd0, 5'd9));
        issue(r_type(7'h20, 5'd2, 5'd0, 3'd0, 5'd9));
        issue(i_type(12'h005, 5'd1, 3'd0, 5'd0));
        issue(r_type(7'h00, 5'd0, 5'd0, 3'd0, 5'd9));
        issue(i_type(12'hfff, 5'd1, 3'd3, 5'd10));
        issue(r_type(7'h01, 5'd1, 5'd2, 3'd0, 5'd11));
        issue(r_type(7'h00, 5'd11, 5'd0, 3'd0, 5'd12));
        idle();

        for (int n = 0; n < 600; n++) begin
            rnd = $urandom;
            if (rnd[3:0] == 4'd0) begin
                idle();
            end else if (rnd[3:0] == 4'd1) begin
                issue(bad_instr());
            end else begin
                issue(rand_instr());
            end
        end

        waited = 0;
        while ((exp_cyc.size() != 0 || ill_cyc.size() != 0) && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (exp_cyc.size() != 0 || ill_cyc.size() != 0) begin
            $display("Error: timed out waiting for the last results to come out");
            timeout_errors++;
        end

        $display("errors: %0d mismatches, %0d strobe errors, %0d timeouts",
                 mismatch_count, strobe_errors, timeout_errors);
        if (mismatch_count + strobe_errors + timeout_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: hdl/exec_core.sv
module exec_core (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                instr_valid,
    input  rv_pkg::instr_t      instr,
    output logic                illegal,
    output logic                result_valid,
    output rv_pkg::reg_addr_t   result_rd,
    output rv_pkg::word_t       result,
    output rv_pkg::alu_flags_t  result_flags
);

    // decoder outputs, valid during cycle 1
    logic                dec_valid;
    rv_pkg::alu_op_t     dec_op;
    rv_pkg::reg_addr_t   dec_rs1;
    rv_pkg::reg_addr_t   dec_rs2;
    rv_pkg::reg_addr_t   dec_rd;
    logic                dec_use_imm;
    rv_pkg::word_t       dec_imm;

    // register file read data
    rv_pkg::word_t       rdata1;
    rv_pkg::word_t       rdata2;

    // alu side
    rv_pkg::word_t       op_b;
    rv_pkg::word_t       alu_res;
    rv_pkg::alu_flags_t  alu_flags;

    instr_decode u_decode (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .dec_valid   (dec_valid),
        .illegal     (illegal),
        .dec_op      (dec_op),
        .dec_rs1     (dec_rs1),
        .dec_rs2     (dec_rs2),
        .dec_rd      (dec_rd),
        .dec_use_imm (dec_use_imm),
        .dec_imm     (dec_imm)
    );

    // write back at the end of cycle 1 so the next instruction reads it
    reg_file u_regs (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs1     (dec_rs1),
        .rs2     (dec_rs2),
        .rdata1  (rdata1),
        .rdata2  (rdata2),
        .wr_en   (dec_valid),
        .wr_addr (dec_rd),
        .wr_data (alu_res)
    );

    // immediate group replaces rs2
    assign op_b = dec_use_imm ? dec_imm : rdata2;

    alu u_alu (
        .a     (rdata1),
        .b     (op_b),
        .op    (dec_op),
        .res   (alu_res),
        .flags (alu_flags)
    );

    // result register, reported even for rd = x0
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result_valid <= 1'b0;
            result_rd    <= '0;
            result       <= '0;
            result_flags <= '0;
        end else begin
            result_valid <= dec_valid;
            if (dec_valid) begin
                result_rd    <= dec_rd;
                result       <= alu_res;
                result_flags <= alu_flags;
            end
        end
    end

endmodule

// File: hdl/reg_file.sv
`include "rv_consts.svh"

module reg_file (
    input  logic                clk,
    input  logic                arst_n,
    input  rv_pkg::reg_addr_t   rs1,
    input  rv_pkg::reg_addr_t   rs2,
    output rv_pkg::word_t       rdata1,
    output rv_pkg::word_t       rdata2,
    input  logic                wr_en,
    input  rv_pkg::reg_addr_t   wr_addr,
    input  rv_pkg::word_t       wr_data
);

    // x0 has no storage
    rv_pkg::word_t regs [1:`REG_COUNT-1];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // combinational reads, x0 forced to zero
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: hdl/instr_decode.sv
`include "rv_consts.svh"

module instr_decode (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                instr_valid,
    input  rv_pkg::instr_t      instr,
    output logic                dec_valid,
    output logic                illegal,
    output rv_pkg::alu_op_t     dec_op,
    output rv_pkg::reg_addr_t   dec_rs1,
    output rv_pkg::reg_addr_t   dec_rs2,
    output rv_pkg::reg_addr_t   dec_rd,
    output logic                dec_use_imm,
    output rv_pkg::word_t       dec_imm
);

    // instruction fields
    logic [6:0]         opcode;
    logic [2:0]         funct3;
    logic [6:0]         funct7;
    logic               alt;
    logic               f7_known;

    // decode result before the output registers
    rv_pkg::alu_op_t    op_c;
    logic               legal_c;
    logic               use_imm_c;
    rv_pkg::word_t      imm_c;

    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7   = instr[31:25];
    assign alt      = (funct7 == `FUNCT7_ALT);
    assign f7_known = (funct7 == `FUNCT7_BASE) || alt;

    always_comb begin
        op_c      = rv_pkg::alu_add;
        legal_c   = 1'b0;
        use_imm_c = 1'b0;
        imm_c     = {{(`XLEN-12){instr[31]}}, instr[31:20]};

        // funct3 to the base operation, alt forms patched below
        case (funct3)
            `F3_ADD_SUB: op_c = alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
            `F3_SLL:     op_c = rv_pkg::alu_sll;
            `F3_SLT:     op_c = rv_pkg::alu_slt;
            `F3_SLTU:    op_c = rv_pkg::alu_sltu;
            `F3_XOR:     op_c = rv_pkg::alu_xor;
            `F3_SRL_SRA: op_c = alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
            `F3_OR:      op_c = rv_pkg::alu_or;
            default:     op_c = rv_pkg::alu_and;
        endcase

        case (opcode)
            `OPC_OP: begin
                // alt marker only on add/sub and srl/sra
                if (alt) begin
                    legal_c = (funct3 == `F3_ADD_SUB) || (funct3 == `F3_SRL_SRA);
                end else begin
                    legal_c = f7_known;
                end
            end
            `OPC_OP_IMM: begin
                use_imm_c = 1'b1;
                case (funct3)
                    `F3_ADD_SUB: begin
                        // no subi exists, upper bits are immediate so always addi
                        op_c    = rv_pkg::alu_add;
                        legal_c = 1'b1;
                    end
                    `F3_SLL: begin
                        legal_c = (funct7 == `FUNCT7_BASE);
                        imm_c   = {{(`XLEN-`SHAMT_W){1'b0}}, instr[24:20]};
                    end
                    `F3_SRL_SRA: begin
                        legal_c = f7_known;
                        imm_c   = {{(`XLEN-`SHAMT_W){1'b0}}, instr[24:20]};
                    end
                    default: begin
                        legal_c = 1'b1;
                    end
                endcase
            end
            default: begin
                legal_c = 1'b0;
            end
        endcase
    end

    // strobes
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_valid <= 1'b0;
            illegal   <= 1'b0;
        end else begin
            dec_valid <= instr_valid & legal_c;
            illegal   <= instr_valid & ~legal_c;
        end
    end

    // decoded fields, only meaningful while dec_valid is high
    always_ff @(posedge clk) begin
        if (instr_valid) begin
            dec_op      <= op_c;
            dec_rs1     <= instr[19:15];
            dec_rs2     <= instr[24:20];
            dec_rd      <= instr[11:7];
            dec_use_imm <= use_imm_c;
            dec_imm     <= imm_c;
        end
    end

endmodule

// File: alu/alu.sv
`include "rv_consts.svh"

module alu (
    input  rv_pkg::word_t      a,
    input  rv_pkg::word_t      b,
    input  rv_pkg::alu_op_t    op,
    output rv_pkg::word_t      res,
    output rv_pkg::alu_flags_t flags
);

    // adder operand and carry in
    rv_pkg::word_t      b_op;
    logic               cin;

    // 33-bit sum, top bit is carry out
    logic [`XLEN:0]     sum;
    rv_pkg::word_t      s;
    logic               co;

    // overflow of whatever the adder did this cycle
    logic               add_ov;
    logic               is_arith;
    logic               is_cmp;
    logic [`SHAMT_W-1:0] shamt;

    // sub, slt and sltu all run the adder as a - b
    always_comb begin
        b_op = b;
        cin  = 1'b0;
        case (op)
            rv_pkg::alu_sub,
            rv_pkg::alu_slt,
            rv_pkg::alu_sltu: begin
                b_op = ~b;
                cin  = 1'b1;
            end
            default: begin
                b_op = b;
                cin  = 1'b0;
            end
        endcase
    end

    assign sum = {1'b0, a} + {1'b0, b_op} + {{`XLEN{1'b0}}, cin};
    assign s   = sum[`XLEN-1:0];
    assign co  = sum[`XLEN];

    // same-sign inputs giving a different-sign sum
    // b_op is already inverted for the subtract forms
    assign add_ov = (a[`XLEN-1] == b_op[`XLEN-1]) && (s[`XLEN-1] != a[`XLEN-1]);

    // RV32I shifts only look at the low five bits
    assign shamt = b[`SHAMT_W-1:0];

    always_comb begin
        case (op)
            rv_pkg::alu_add,
            rv_pkg::alu_sub: begin
                res = s;
            end
            rv_pkg::alu_slt: begin
                // signed less-than, sign corrected by the overflow
                res = {{(`XLEN-1){1'b0}}, s[`XLEN-1] ^ add_ov};
            end
            rv_pkg::alu_sltu: begin
                // no borrow out means a >= b
                res = {{(`XLEN-1){1'b0}}, ~co};
            end
            rv_pkg::alu_and: begin
                res = a & b;
            end
            rv_pkg::alu_or: begin
                res = a | b;
            end
            rv_pkg::alu_xor: begin
                res = a ^ b;
            end
            rv_pkg::alu_sll: begin
                res = a << shamt;
            end
            rv_pkg::alu_srl: begin
                res = a >> shamt;
            end
            rv_pkg::alu_sra: begin
                res = rv_pkg::word_t'($signed(a) >>> shamt);
            end
            default: begin
                res = '0;
            end
        endcase
    end

    // which ops report overflow and carry
    assign is_arith = (op == rv_pkg::alu_add) || (op == rv_pkg::alu_sub);
    assign is_cmp   = (op == rv_pkg::alu_slt) || (op == rv_pkg::alu_sltu);

    assign flags[`FLAG_OV] = add_ov & is_arith;
    assign flags[`FLAG_CY] = co & (is_arith | is_cmp);
    assign flags[`FLAG_Z]  = ~(|res);
    assign flags[`FLAG_N]  = res[`XLEN-1];

endmodule

// File: common/rv_pkg.sv
`include "rv_consts.svh"

package rv_pkg;

    // one data word: operands, results, immediates
    typedef logic [`XLEN-1:0] word_t;

    // register index
    typedef logic [$clog2(`REG_COUNT)-1:0] reg_addr_t;

    // raw instruction word
    typedef logic [31:0] instr_t;

    // overflow, carry, zero, negative from bit 0 upward
    typedef logic [`FLAG_COUNT-1:0] alu_flags_t;

    // alu operation select
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_slt  = 4'd2,
        alu_sltu = 4'd3,
        alu_and  = 4'd4,
        alu_or   = 4'd5,
        alu_xor  = 4'd6,
        alu_sll  = 4'd7,
        alu_srl  = 4'd8,
        alu_sra  = 4'd9
    } alu_op_t;

endpackage

// File: common/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// datapath and register file sizes
`define XLEN        32
`define REG_COUNT   32
`define SHAMT_W     5
`define FLAG_COUNT  4

// major opcodes handled by the core
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011

// funct3 codes shared by the register and immediate groups
`define F3_ADD_SUB  3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SRL_SRA  3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111

// funct7 values, bit 30 picks sub and sra
`define FUNCT7_BASE 7'b0000000
`define FUNCT7_ALT  7'b0100000

// flag vector bit positions
`define FLAG_OV     0
`define FLAG_CY     1
`define FLAG_Z      2
`define FLAG_N      3

`endif
